//--- difCfgPkg.sv
package difCfgPkg;

  ////////////////////////////////////////
  // Chain layout
  ////////////////////////////////////////

  // Hit-storage chains read out by the board
  localparam int numChains = 4;

  // Words held by one chain RAM
  localparam int ramDepth = 64;

  // Address bits for one chain RAM
  localparam int addrWidth = $clog2(ramDepth);

  ////////////////////////////////////////
  // Data and timing
  ////////////////////////////////////////

  // Hit word as delivered by the front end
  localparam int wordWidth = 16;

  // Cycles that readoutDone stays high per readout
  localparam int doneHoldCycles = 11;

endpackage

//--- difTypesPkg.sv
package difTypesPkg;

  import difCfgPkg::*;

  ////////////////////////////////////////
  // Plain vectors
  ////////////////////////////////////////

  // One bit per chain, used for enables, end pulses and grants
  typedef logic [numChains-1:0] chainMaskT;

  // Chain number
  typedef logic [$clog2(numChains)-1:0] chainIdxT;

  // Address into one chain RAM
  typedef logic [addrWidth-1:0] ramAddrT;

  // Fill count, one extra bit so a full RAM is representable
  typedef logic [addrWidth:0] ptrT;

  // Hit word
  typedef logic [wordWidth-1:0] dataWordT;

  ////////////////////////////////////////
  // Chain drain FSM
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    idle,
    drain,
    finish
  } readStateE;

  ////////////////////////////////////////
  // Buses
  ////////////////////////////////////////

  // Host write into one chain RAM
  typedef struct packed {
    logic     en;
    chainIdxT chain;
    dataWordT data;
  } ramWrT;

  // Tagged word on the merged output stream
  typedef struct packed {
    logic     valid;
    chainIdxT chain;
    dataWordT data;
  } chainWordT;

endpackage

//--- chainReadout.sv
`timescale 1ns/1ps

module chainReadout
  import difCfgPkg::*, difTypesPkg::*;
(
  input  logic     OnceEnd,
  input  logic     reset_n,
  input  logic     wrEn,
  input  dataWordT wrData,
  input  logic     chainStart,
  input  logic     grant,
  output logic     pending,
  output dataWordT rdData,
  output logic     chainEnd
);

  // Hit storage
  dataWordT ram [ramDepth];

  readStateE state;
  ptrT       wrPtr;
  ptrT       rdPtr;
  ptrT       rdPtrNext;
  ramAddrT   wrAddr;
  ramAddrT   rdAddr;
  logic      full;
  logic      wrFire;
  logic      readFire;

  ////////////////////////////////////////
  // Pointer decode
  ////////////////////////////////////////

  assign full      = (wrPtr == ptrT'(ramDepth));
  // Writes to a full chain are dropped
  assign wrFire    = wrEn && !full;
  assign wrAddr    = wrPtr[addrWidth-1:0];
  assign rdAddr    = rdPtr[addrWidth-1:0];
  assign rdPtrNext = rdPtr + ptrT'(1);

  // Words left while draining
  assign pending  = (state == drain) && (rdPtr != wrPtr);
  assign readFire = grant && pending;

  // One-cycle end marker, right after the last read
  assign chainEnd = (state == finish);

  ////////////////////////////////////////
  // RAM ports
  ////////////////////////////////////////

  always_ff @(posedge OnceEnd) begin
    if (wrFire) begin
      ram[wrAddr] <= wrData;
    end
  end

  // Read data valid the cycle after the grant
  always_ff @(posedge OnceEnd) begin
    if (readFire) begin
      rdData <= ram[rdAddr];
    end
  end

  ////////////////////////////////////////
  // Drain FSM and pointers
  ////////////////////////////////////////

  always_ff @(posedge OnceEnd or negedge reset_n) begin
    if (!reset_n) begin
      state <= idle;
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (wrFire) begin
        wrPtr <= wrPtr + ptrT'(1);
      end
      case (state)
        idle: begin
          // Empty chain goes straight to the end pulse
          if (chainStart) begin
            state <= (wrPtr == '0) ? finish : drain;
          end
        end
        drain: begin
          if (readFire) begin
            rdPtr <= rdPtrNext;
            // Last word issued
            if (rdPtrNext == wrPtr) begin
              state <= finish;
            end
          end
        end
        finish: begin
          // Chain left empty for the next load
          wrPtr <= '0;
          rdPtr <= '0;
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Host loads only between readouts
  assert property (@(posedge OnceEnd) disable iff (!reset_n)
    wrEn |-> state == idle);

  assert property (@(posedge OnceEnd) disable iff (!reset_n)
    chainEnd |=> !chainEnd);

endmodule

//--- chainDataMerge.sv
`timescale 1ns/1ps

module chainDataMerge
  import difCfgPkg::*, difTypesPkg::*;
(
  input  logic      OnceEnd,
  input  logic      reset_n,
  input  chainMaskT pending,
  input  dataWordT  rdData [numChains],
  output chainMaskT grant,
  output chainWordT outWord
);

  chainIdxT grantIdx;
  logic     grantValidQ;
  chainIdxT grantIdxQ;
  logic     outValid;
  chainIdxT outChain;
  dataWordT outData;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  // Isolate lowest pending bit
  assign grant = pending & (~pending + chainMaskT'(1));

  // One-hot to index
  always_comb begin
    grantIdx = '0;
    for (int i = 0; i < numChains; i++) begin
      if (grant[i]) begin
        grantIdx = chainIdxT'(i);
      end
    end
  end

  // Remember who read this cycle
  always_ff @(posedge OnceEnd or negedge reset_n) begin
    if (!reset_n) begin
      grantValidQ <= 1'b0;
      grantIdxQ   <= '0;
    end else begin
      grantValidQ <= |grant;
      grantIdxQ   <= grantIdx;
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge OnceEnd or negedge reset_n) begin
    if (!reset_n) begin
      outValid <= 1'b0;
    end else begin
      outValid <= grantValidQ;
    end
  end

  // RAM data of the chain granted last cycle
  always_ff @(posedge OnceEnd) begin
    outChain <= grantIdxQ;
    outData  <= rdData[grantIdxQ];
  end

  assign outWord.valid = outValid;
  assign outWord.chain = outChain;
  assign outWord.data  = outData;

  // At most one chain reads per cycle
  assert property (@(posedge OnceEnd) disable iff (!reset_n)
    $onehot0(grant));

endmodule

//--- readoutDoneSync.sv
`timescale 1ns/1ps

module readoutDoneSync
  import difCfgPkg::*, difTypesPkg::*;
(
  input  logic      OnceEnd,
  input  logic      reset_n,
  input  logic      arm,
  input  chainMaskT chainEnd,
  input  chainMaskT chainEnable,
  output logic      readoutDone
);

  // Wide enough to hold the full done length
  typedef logic [$clog2(doneHoldCycles+1)-1:0] holdCntT;

  chainMaskT hitFlags;
  logic      armed;
  logic      allEnded;
  logic      doneCmp;
  holdCntT   holdCnt;

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  // Arm pulse counts too, so a zero mask completes at once
  assign allEnded = (armed || arm) && (hitFlags == chainEnable);

  always_ff @(posedge OnceEnd or negedge reset_n) begin
    if (!reset_n) begin
      armed   <= 1'b0;
      doneCmp <= 1'b0;
    end else begin
      doneCmp <= allEnded;
      // Disarm as soon as the compare fires
      if (allEnded) begin
        armed <= 1'b0;
      end else if (arm) begin
        armed <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Hit flags and hold counter
  ////////////////////////////////////////

  always_ff @(posedge OnceEnd or negedge reset_n) begin
    if (!reset_n) begin
      hitFlags <= '0;
      holdCnt  <= '0;
    end else begin
      if (doneCmp) begin
        // First done cycle, start clean for the next readout
        hitFlags <= '0;
        holdCnt  <= holdCntT'(doneHoldCycles);
      end else begin
        hitFlags <= hitFlags | chainEnd;
        if (holdCnt != '0) begin
          holdCnt <= holdCnt - holdCntT'(1);
        end
      end
    end
  end

  assign readoutDone = (holdCnt != '0);

  // Only enabled chains may report an end
  assert property (@(posedge OnceEnd) disable iff (!reset_n)
    armed |-> (chainEnd & ~chainEnable) == '0);

endmodule

//--- difReadoutTop.sv
`timescale 1ns/1ps

module difReadoutTop
  import difCfgPkg::*, difTypesPkg::*;
(
  input  logic      OnceEnd,
  input  logic      reset_n,
  input  logic      startReadout,
  input  chainMaskT chainEnable,
  input  ramWrT     ramWr,
  output logic      busy,
  output logic      readoutDone,
  output chainWordT outWord
);

  chainMaskT enableQ;
  logic      startAccept;
  logic      startQ;
  logic      doneQ;
  chainMaskT chainStart;
  chainMaskT wrEnVec;
  chainMaskT pending;
  chainMaskT grant;
  chainMaskT chainEnd;
  dataWordT  rdData [numChains];

  ////////////////////////////////////////
  // Start and busy
  ////////////////////////////////////////

  // Starts while busy are ignored
  assign startAccept = startReadout && !busy;

  always_ff @(posedge OnceEnd or negedge reset_n) begin
    if (!reset_n) begin
      enableQ <= '0;
      startQ  <= 1'b0;
      doneQ   <= 1'b0;
      busy    <= 1'b0;
    end else begin
      startQ <= startAccept;
      doneQ  <= readoutDone;
      if (startAccept) begin
        enableQ <= chainEnable;
        busy    <= 1'b1;
      end else if (doneQ && !readoutDone) begin
        // Release one cycle after done falls
        busy <= 1'b0;
      end
    end
  end

  // One-cycle start to enabled chains only
  assign chainStart = startQ ? enableQ : '0;

  // Host write decode
  always_comb begin
    for (int i = 0; i < numChains; i++) begin
      wrEnVec[i] = ramWr.en && (ramWr.chain == chainIdxT'(i));
    end
  end

  ////////////////////////////////////////
  // Chains, merger and done sync
  ////////////////////////////////////////

  for (genvar c = 0; c < numChains; c++) begin : gChain
    chainReadout uChain (
      .OnceEnd    (OnceEnd),
      .reset_n    (reset_n),
      .wrEn       (wrEnVec[c]),
      .wrData     (ramWr.data),
      .chainStart (chainStart[c]),
      .grant      (grant[c]),
      .pending    (pending[c]),
      .rdData     (rdData[c]),
      .chainEnd   (chainEnd[c])
    );
  end

  chainDataMerge uMerge (
    .OnceEnd (OnceEnd),
    .reset_n (reset_n),
    .pending (pending),
    .rdData  (rdData),
    .grant   (grant),
    .outWord (outWord)
  );

  readoutDoneSync uDoneSync (
    .OnceEnd     (OnceEnd),
    .reset_n     (reset_n),
    .arm         (startQ),
    .chainEnd    (chainEnd),
    .chainEnable (enableQ),
    .readoutDone (readoutDone)
  );

  // Host must not load during a readout
  assert property (@(posedge OnceEnd) disable iff (!reset_n)
    ramWr.en |-> !busy);

endmodule

//--- tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen (
  output logic OnceEnd,
  output logic reset_n
);

  // 4 ns period
  initial begin
    OnceEnd = 1'b0;
    forever #2 OnceEnd = ~OnceEnd;
  end

  // Reset low for the first 8 rising edges
  initial begin
    reset_n = 1'b0;
    repeat (8) @(posedge OnceEnd);
    reset_n <= 1'b1;
  end

endmodule

//--- tbChecker.sv
`timescale 1ns/1ps

module tbChecker
  import difCfgPkg::*, difTypesPkg::*;
(
  input  logic      OnceEnd,
  input  logic      reset_n,
  input  logic      startReadout,
  input  chainMaskT chainEnable,
  input  ramWrT     ramWr,
  input  logic      busy,
  input  logic      readoutDone,
  input  chainWordT outWord,
  output int        wordErrors,
  output int        ctrlErrors,
  output int        doneCount
);

  // Expected words per chain, in write order
  dataWordT  expQ [numChains][$];
  dataWordT  expWord;
  chainMaskT mask;
  logic      modelBusy;
  logic      readoutOpen;
  logic      prevDone;
  logic      haveLast;
  chainIdxT  lastChain;
  int        holdLen;

  always @(posedge OnceEnd) begin
    if (!reset_n) begin
      for (int c = 0; c < numChains; c++) begin
        expQ[c].delete();
      end
      mask        = '0;
      modelBusy   = 1'b0;
      readoutOpen = 1'b0;
      prevDone    = 1'b0;
      haveLast    = 1'b0;
      lastChain   = '0;
      holdLen     = 0;
      wordErrors  = 0;
      ctrlErrors  = 0;
      doneCount   = 0;
    end else begin
      ////////////////////////////////////////
      // Host writes
      ////////////////////////////////////////
      if (ramWr.en) begin
        // Full chain drops the word
        if (expQ[ramWr.chain].size() < ramDepth) begin
          expQ[ramWr.chain].push_back(ramWr.data);
        end
      end

      // Busy follows start and done
      if (busy !== modelBusy) begin
        $display("Error: busy = 0x%0h, expected 0x%0h", busy, modelBusy);
        ctrlErrors++;
      end

      ////////////////////////////////////////
      // Output stream
      ////////////////////////////////////////
      if (outWord.valid) begin
        if (!readoutOpen) begin
          $display("Word from chain %0d appeared outside a readout", outWord.chain);
          wordErrors++;
        end
        if (!mask[outWord.chain]) begin
          $display("Error: outWord.chain = 0x%0h, enable mask 0x%0h",
                   outWord.chain, mask);
          wordErrors++;
        end else if (expQ[outWord.chain].size() == 0) begin
          $display("Chain %0d sent a word but none was written", outWord.chain);
          wordErrors++;
        end else begin
          expWord = expQ[outWord.chain].pop_front();
          if (outWord.data !== expWord) begin
            $display("Error: outWord.data = 0x%04h, expected 0x%04h (chain %0d)",
                     outWord.data, expWord, outWord.chain);
            wordErrors++;
          end
        end
        // Lowest pending chain wins, so tags only climb
        if (haveLast && outWord.chain < lastChain) begin
          $display("Error: outWord.chain = 0x%0h after chain 0x%0h",
                   outWord.chain, lastChain);
          wordErrors++;
        end
        lastChain = outWord.chain;
        haveLast  = 1'b1;
      end

      ////////////////////////////////////////
      // Readout done
      ////////////////////////////////////////
      if (readoutDone && !prevDone) begin
        if (!readoutOpen) begin
          $display("readoutDone rose with no readout in progress");
          ctrlErrors++;
        end
        for (int c = 0; c < numChains; c++) begin
          if (mask[c] && expQ[c].size() != 0) begin
            $display("Chain %0d still holds %0d words when readoutDone rose",
                     c, expQ[c].size());
            wordErrors++;
          end
        end
        readoutOpen = 1'b0;
        holdLen     = 0;
        doneCount++;
      end
      if (readoutDone) begin
        holdLen++;
      end
      if (!readoutDone && prevDone) begin
        if (holdLen != doneHoldCycles) begin
          $display("Error: readoutDone high for 0x%0h cycles, expected 0x%0h",
                   holdLen, doneHoldCycles);
          ctrlErrors++;
        end
        // Busy drops on the next edge
        modelBusy = 1'b0;
      end
      prevDone = readoutDone;

      // Accepted start only while idle
      if (startReadout && !modelBusy) begin
        mask        = chainEnable;
        modelBusy   = 1'b1;
        readoutOpen = 1'b1;
        haveLast    = 1'b0;
      end
    end
  end

endmodule

//--- tbDifReadout.sv
`timescale 1ns/1ps

module tbDifReadout
  import difCfgPkg::*, difTypesPkg::*;
();

  localparam int numRounds    = 40;
  localparam int maxWords     = 20;
  localparam int drainTimeout = 1000;
  localparam int shortTimeout = 20;

  // Signal selectors for the wait task
  localparam int selReset = 0;
  localparam int selDone  = 1;
  localparam int selBusy  = 2;

  logic      OnceEnd;
  logic      reset_n;
  logic      startReadout;
  chainMaskT chainEnable;
  ramWrT     ramWr;
  logic      busy;
  logic      readoutDone;
  chainWordT outWord;
  int        wordErrors;
  int        ctrlErrors;
  int        doneCount;
  int        timeouts;
  int        countErrors;
  bit        aborted;

  tbClockGen uClock (
    .OnceEnd (OnceEnd),
    .reset_n (reset_n)
  );

  difReadoutTop dut (
    .OnceEnd      (OnceEnd),
    .reset_n      (reset_n),
    .startReadout (startReadout),
    .chainEnable  (chainEnable),
    .ramWr        (ramWr),
    .busy         (busy),
    .readoutDone  (readoutDone),
    .outWord      (outWord)
  );

  tbChecker uChecker (
    .OnceEnd      (OnceEnd),
    .reset_n      (reset_n),
    .startReadout (startReadout),
    .chainEnable  (chainEnable),
    .ramWr        (ramWr),
    .busy         (busy),
    .readoutDone  (readoutDone),
    .outWord      (outWord),
    .wordErrors   (wordErrors),
    .ctrlErrors   (ctrlErrors),
    .doneCount    (doneCount)
  );

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Poll one signal per edge until it reaches the level
  task automatic waitLevel(input int sel, input logic level, input int limit,
                           input string what, output bit ok);
    int   cycles;
    logic now;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < limit) begin
      @(posedge OnceEnd);
      case (sel)
        selDone: now = readoutDone;
        selBusy: now = busy;
        default: now = reset_n;
      endcase
      ok = (now === level);
      cycles++;
    end
    if (!ok) begin
      $display("Timeout: %s not reached within %0d cycles", what, limit);
      timeouts++;
    end
  endtask

  // Random count of random words per chain, with the odd idle gap
  task automatic loadChains();
    int count;
    for (int c = 0; c < numChains; c++) begin
      count = $urandom_range(0, maxWords);
      for (int w = 0; w < count; w++) begin
        @(posedge OnceEnd);
        ramWr.en    <= ($urandom_range(0, 3) != 0);
        ramWr.chain <= chainIdxT'(c);
        ramWr.data  <= dataWordT'($urandom);
      end
    end
    @(posedge OnceEnd);
    ramWr.en <= 1'b0;
  endtask

  task automatic pulseStart(input chainMaskT mask);
    @(posedge OnceEnd);
    startReadout <= 1'b1;
    chainEnable  <= mask;
    @(posedge OnceEnd);
    startReadout <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    bit ok;
    startReadout = 1'b0;
    chainEnable  = '0;
    ramWr        = '0;
    timeouts     = 0;
    countErrors  = 0;
    aborted      = 1'b0;
    void'($urandom(90609));

    waitLevel(selReset, 1'b1, shortTimeout, "reset release", ok);
    aborted = !ok;

    for (int r = 0; r < numRounds && !aborted; r++) begin
      loadChains();
      pulseStart(chainMaskT'($urandom_range(0, 15)));
      // Second start lands while busy and must be ignored
      if ($urandom_range(0, 1) == 1) begin
        repeat ($urandom_range(1, 4)) @(posedge OnceEnd);
        pulseStart(chainMaskT'($urandom_range(0, 15)));
      end
      waitLevel(selDone, 1'b1, drainTimeout, "readoutDone high", ok);
      if (ok) begin
        waitLevel(selDone, 1'b0, shortTimeout, "readoutDone low", ok);
      end
      if (ok) begin
        waitLevel(selBusy, 1'b0, shortTimeout, "busy low", ok);
      end
      aborted = !ok;
    end

    // One done per round, none from ignored starts
    if (!aborted && doneCount != numRounds) begin
      $display("Saw %0d readouts finish instead of %0d", doneCount, numRounds);
      countErrors++;
    end

    $display("Errors: words %0d, control %0d, count %0d, timeouts %0d",
             wordErrors, ctrlErrors, countErrors, timeouts);
    if (wordErrors + ctrlErrors + countErrors + timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- difReadout.f
difCfgPkg.sv
difTypesPkg.sv
chainReadout.sv
chainDataMerge.sv
readoutDoneSync.sv
difReadoutTop.sv
tbClockGen.sv
tbChecker.sv
tbDifReadout.sv

//--- Bender.yml
package:
  name: difReadout

sources:
  # Packages
  - difCfgPkg.sv
  - difTypesPkg.sv
  # RTL
  - chainReadout.sv
  - chainDataMerge.sv
  - readoutDoneSync.sv
  - difReadoutTop.sv
  # Testbench
  - target: test
    files:
      - tbClockGen.sv
      - tbChecker.sv
      - tbDifReadout.sv
